// ==== hw/link_pkg.sv ====
// link word description; LINK_DATA_WIDTH is only the default, the top level may override it
package link_pkg;

    // default width of one word carried on the link
    // any width works, the receiver never slices the word
    parameter int LINK_DATA_WIDTH = 32;

    // the sender presents one word per strobe toggle
    // at most one toggle per link clock cycle
    // a word counts only while link_active is high

endpackage

// ==== hw/rx_pkg.sv ====
// slot ring and synchronizer description; ring logic assumes exactly 3 slots, depth 2 or more
package rx_pkg;

    // slot registers in the ring
    parameter int NUM_SLOTS = 3;

    // default synchronizer depth in clk flip-flops
    parameter int SYNC_STAGES_DEFAULT = 2;

    // slot index, value 3 is never used
    typedef logic [$clog2(NUM_SLOTS)-1:0] slot_idx_t;

    // one toggle flag or one flip bit per slot
    typedef logic [NUM_SLOTS-1:0] slot_flags_t;

    // ring order 0, 1, 2, back to 0
    // shared by the write side and the read side so both walk the same order
    function automatic slot_idx_t next_slot(input slot_idx_t idx);
        slot_idx_t last;
        last = slot_idx_t'(NUM_SLOTS - 1);
        if (idx == last) begin
            return '0;
        end
        return idx + slot_idx_t'(1);
    endfunction

endpackage

// ==== hw/link_capture.sv ====
// link_clk side; link may drop link_active only after a multiple of three accepted words
`timescale 1ns/10ps

module link_capture #(
    parameter int DATA_WIDTH = link_pkg::LINK_DATA_WIDTH
) (
    input  logic                  link_clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] link_data,
    input  logic                  link_strobe,
    input  logic                  link_active,
    output logic [DATA_WIDTH-1:0] slot_data_0,
    output logic [DATA_WIDTH-1:0] slot_data_1,
    output logic [DATA_WIDTH-1:0] slot_data_2,
    output rx_pkg::slot_flags_t   slot_flags
);

    import rx_pkg::*;

    // previous strobe level, any difference means a new word
    logic strobe_q;

    // ring position of the next write
    slot_idx_t wr_ptr;

    // one toggle flag per slot
    slot_flags_t flags_q;

    // slot registers
    logic [DATA_WIDTH-1:0] slot_mem [NUM_SLOTS];

    // new word on the link
    logic strobe_edge;

    // new word that is actually taken
    logic write_en;

    assign strobe_edge = link_strobe != strobe_q;
    assign write_en    = strobe_edge && link_active;

    // strobe history
    // tracks even while inactive so dropped words are not replayed later
    always_ff @(posedge link_clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= link_strobe;
        end
    end

    // write pointer
    // parked on slot 0 while the link is idle
    always_ff @(posedge link_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (!link_active) begin
            wr_ptr <= '0;
        end else if (write_en) begin
            wr_ptr <= next_slot(wr_ptr);
        end
    end

    // slot payload, written on the same edge as its flag
    always_ff @(posedge link_clk) begin
        if (write_en) begin
            slot_mem[wr_ptr] <= link_data;
        end
    end

    // flag of the written slot toggles once per word
    // the reader sees the toggle only after the data has settled
    always_ff @(posedge link_clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (write_en) begin
            flags_q[wr_ptr] <= ~flags_q[wr_ptr];
        end
    end

    // slots leave as plain registers
    // they cross to clk guarded by the flag handshake
    assign slot_data_0 = slot_mem[0];
    assign slot_data_1 = slot_mem[1];
    assign slot_data_2 = slot_mem[2];
    assign slot_flags  = flags_q;

    // pointer stays inside the ring, 3 would write past the last slot
    wr_ptr_in_ring: assert property (
        @(posedge link_clk) disable iff (!rst_n)
        wr_ptr < slot_idx_t'(NUM_SLOTS)
    ) else $error("link_capture write pointer left the slot ring");

endmodule

// ==== hw/flag_sync.sv ====
// clk side flag synchronizer; SYNC_STAGES must be 2 or more, flags must toggle slower than clk
`timescale 1ns/10ps

module flag_sync #(
    parameter int SYNC_STAGES = rx_pkg::SYNC_STAGES_DEFAULT
) (
    input  logic                clk,
    input  logic                rst_n,
    input  rx_pkg::slot_flags_t slot_flags,
    output rx_pkg::slot_flags_t slot_flips
);

    import rx_pkg::*;

    // synchronizer chain, stage 0 may go metastable
    slot_flags_t sync_q [SYNC_STAGES];

    // last settled value one cycle back
    slot_flags_t hist_q;

    // flags are independent toggles
    // a skew between bits only shifts which cycle each flip lands in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            hist_q <= '0;
        end else begin
            sync_q[0] <= slot_flags;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            hist_q <= sync_q[SYNC_STAGES-1];
        end
    end

    // one cycle pulse per settled toggle
    assign slot_flips = sync_q[SYNC_STAGES-1] ^ hist_q;

    // a flag toggling faster than clk would merge two words into one pulse
    // so a flip never repeats on the next cycle
    flip_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        (slot_flips & $past(slot_flips)) == '0
    ) else $error("flag_sync flip held for two cycles, link words too close together");

endmodule

// ==== hw/word_selector.sv ====
// clk side word output; no back-pressure, a consumer that misses data_valid loses the word
`timescale 1ns/10ps

module word_selector #(
    parameter int DATA_WIDTH = link_pkg::LINK_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rx_pkg::slot_flags_t   slot_flips,
    input  logic [DATA_WIDTH-1:0] slot_data_0,
    input  logic [DATA_WIDTH-1:0] slot_data_1,
    input  logic [DATA_WIDTH-1:0] slot_data_2,
    output logic [DATA_WIDTH-1:0] word_data,
    output logic                  data_valid
);

    import rx_pkg::*;

    // next slot to hand out, follows the write order
    slot_idx_t rd_ptr;

    // flip seen on the slot under the pointer
    logic take;

    // slot under the pointer
    logic [DATA_WIDTH-1:0] slot_sel;

    // flips of other slots wait until the pointer comes round
    assign take = slot_flips[rd_ptr];

    // slot mux
    // the chosen slot is stable here, its flip has already crossed
    always_comb begin
        case (rd_ptr)
            2'd0: begin
                slot_sel = slot_data_0;
            end
            2'd1: begin
                slot_sel = slot_data_1;
            end
            default: begin
                slot_sel = slot_data_2;
            end
        endcase
    end

    // read pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (take) begin
            rd_ptr <= next_slot(rd_ptr);
        end
    end

    // output word, held between strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_data <= '0;
        end else if (take) begin
            word_data <= slot_sel;
        end
    end

    // valid strobe, one clk cycle per word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= take;
        end
    end

    // read pointer stays inside the ring
    rd_ptr_in_ring: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_ptr < slot_idx_t'(NUM_SLOTS)
    ) else $error("word_selector read pointer left the slot ring");

    // back to back strobes mean words arrived faster than two clk periods
    valid_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_valid |=> !data_valid
    ) else $error("word_selector data_valid high for two cycles in a row");

endmodule

// ==== hw/strobe_link_rx.sv ====
// receiver top; word interval at least 2 clk periods, 3 intervals longer than sync latency
`timescale 1ns/10ps

module strobe_link_rx #(
    parameter int DATA_WIDTH  = link_pkg::LINK_DATA_WIDTH,
    parameter int SYNC_STAGES = rx_pkg::SYNC_STAGES_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  link_clk,
    input  logic [DATA_WIDTH-1:0] link_data,
    input  logic                  link_strobe,
    input  logic                  link_active,
    output logic [DATA_WIDTH-1:0] word_data,
    output logic                  data_valid
);

    import rx_pkg::*;

    // slot payload, link_clk domain
    logic [DATA_WIDTH-1:0] slot_data_0;
    logic [DATA_WIDTH-1:0] slot_data_1;
    logic [DATA_WIDTH-1:0] slot_data_2;

    // raw toggle flags, link_clk domain
    slot_flags_t slot_flags;

    // settled flips, clk domain
    slot_flags_t slot_flips;

    // sender side ring writer
    link_capture #(
        .DATA_WIDTH (DATA_WIDTH)
    ) link_capture_i (
        .link_clk    (link_clk),
        .rst_n       (rst_n),
        .link_data   (link_data),
        .link_strobe (link_strobe),
        .link_active (link_active),
        .slot_data_0 (slot_data_0),
        .slot_data_1 (slot_data_1),
        .slot_data_2 (slot_data_2),
        .slot_flags  (slot_flags)
    );

    // only the flags cross through flip-flops
    flag_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) flag_sync_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot_flags (slot_flags),
        .slot_flips (slot_flips)
    );

    // local side reader
    word_selector #(
        .DATA_WIDTH (DATA_WIDTH)
    ) word_selector_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .slot_flips  (slot_flips),
        .slot_data_0 (slot_data_0),
        .slot_data_1 (slot_data_1),
        .slot_data_2 (slot_data_2),
        .word_data   (word_data),
        .data_valid  (data_valid)
    );

endmodule

// ==== testbench/tb_strobe_link_rx.sv ====
// run from the project root so testbench/link_tests.txt opens; link_clk 20 ns against clk 8 ns
`timescale 1ns/10ps

module tb_strobe_link_rx;

    // tb constants
    localparam int    DATA_W        = 32;
    localparam int    SYNC_DEPTH    = 2;
    localparam int    LCG_SEED      = 74200;
    localparam int    DRAIN_TIMEOUT = 400;
    localparam int    FINAL_IDLE    = 50;
    localparam int    MAX_LINES     = 500;
    localparam string TEST_FILE     = "testbench/link_tests.txt";

    // DUT ports all driven from time 0
    logic              clk = 1'b0;
    logic              link_clk = 1'b0;
    logic              rst_n = 1'b0;
    logic [DATA_W-1:0] link_data = '0;
    logic              link_strobe = 1'b0;
    logic              link_active = 1'b0;
    logic [DATA_W-1:0] word_data;
    logic              data_valid;

    // scoreboard
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] exp_word;
    logic [31:0]       lcg_state = 32'(LCG_SEED);
    logic              valid_q = 1'b0;
    int                accepted_count = 0;
    int                strobe_count = 0;
    int                data_errors = 0;
    int                protocol_errors = 0;
    int                timeout_errors = 0;

    // local clock 8 ns
    always #4 clk = ~clk;

    // sender clock 20 ns with no phase relation to clk
    always #10 link_clk = ~link_clk;

    strobe_link_rx #(
        .DATA_WIDTH  (DATA_W),
        .SYNC_STAGES (SYNC_DEPTH)
    ) strobe_link_rx_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .link_clk    (link_clk),
        .link_data   (link_data),
        .link_strobe (link_strobe),
        .link_active (link_active),
        .word_data   (word_data),
        .data_valid  (data_valid)
    );

    // park 1 ns past the link_clk edge
    task automatic link_cycle();
        @(posedge link_clk);
        #1;
    endtask

    // numerical recipes LCG step
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // one strobe toggle with a new word
    // accept comes from the test file and must match link_active
    task automatic send_word(input logic [DATA_W-1:0] word, input bit accept);
        link_cycle();
        link_data   = word;
        link_strobe = ~link_strobe;
        assert (accept == link_active) else begin
            $display("test file expectation for word %h disagrees with link_active", word);
            protocol_errors++;
        end
        if (accept) begin
            exp_q.push_back(word);
            accepted_count++;
        end
    endtask

    // link_active may drop only between ring laps
    task automatic set_active(input bit level);
        link_cycle();
        if (!level) begin
            assert (accepted_count % 3 == 0) else begin
                $display("link deactivated after %0d accepted words, not a whole ring lap",
                         accepted_count);
                protocol_errors++;
            end
        end
        link_active = level;
    endtask

    // nothing may come out before the first send
    task automatic check_reset_state();
        repeat (6) begin
            @(negedge clk);
            assert (data_valid == 1'b0) else begin
                $display("[ERROR] data_valid expected %h actual %h", 1'b0, data_valid);
                data_errors++;
            end
            assert (word_data == '0) else begin
                $display("[ERROR] word_data expected %h actual %h", {DATA_W{1'b0}}, word_data);
                data_errors++;
            end
        end
    endtask

    // command interpreter for the stimulus file
    task automatic run_test_file();
        int                fd;
        int                rc;
        int                n;
        int                line_no;
        bit                done;
        logic [DATA_W-1:0] word;
        string             line;
        string             cmd;
        string             flag;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", TEST_FILE);
            protocol_errors++;
        end else begin
            done    = 1'b0;
            line_no = 0;
            while (!done && line_no < MAX_LINES) begin
                rc = $fgets(line, fd);
                line_no++;
                if (rc == 0) begin
                    $display("stimulus file ended without an end command");
                    protocol_errors++;
                    done = 1'b1;
                end else if (line.len() > 1 && line.getc(0) != "#") begin
                    rc = $sscanf(line, "%s", cmd);
                    if (cmd == "send") begin
                        rc = $sscanf(line, "%s %h %s", cmd, word, flag);
                        send_word(word, flag == "a");
                    end else if (cmd == "idle") begin
                        rc = $sscanf(line, "%s %d", cmd, n);
                        repeat (n) link_cycle();
                    end else if (cmd == "active") begin
                        rc = $sscanf(line, "%s %d", cmd, n);
                        set_active(n != 0);
                    end else if (cmd == "random") begin
                        rc = $sscanf(line, "%s %d %s", cmd, n, flag);
                        // one word every link cycle
                        repeat (n) begin
                            lcg_state = lcg_next(lcg_state);
                            send_word(lcg_state, flag == "a");
                        end
                    end else if (cmd == "end") begin
                        done = 1'b1;
                    end else begin
                        $display("unknown command on stimulus line %0d", line_no);
                        protocol_errors++;
                    end
                end
            end
            if (!done) begin
                $display("stimulus file has no end command within %0d lines", MAX_LINES);
                protocol_errors++;
            end
            $fclose(fd);
        end
    endtask

    // every accepted word must come out
    task automatic wait_queue_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            $display("timed out with %0d accepted words never delivered", exp_q.size());
            timeout_errors++;
        end
    endtask

    task automatic report_and_finish();
        $display("errors data %0d protocol %0d timeout %0d, strobes %0d, accepted words %0d",
                 data_errors, protocol_errors, timeout_errors, strobe_count, accepted_count);
        if (data_errors + protocol_errors + timeout_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    // output monitor
    // sampled mid cycle since outputs move on the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(data_valid && valid_q)) else begin
                $display("data_valid stayed high for two clk cycles at %0t", $time);
                protocol_errors++;
            end
            if (data_valid) begin
                strobe_count++;
                assert (exp_q.size() > 0) else begin
                    $display("data_valid strobe with no accepted word pending at %0t", $time);
                    protocol_errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_word = exp_q.pop_front();
                    assert (word_data == exp_word) else begin
                        $display("[ERROR] word_data expected %h actual %h", exp_word, word_data);
                        data_errors++;
                    end
                end
            end
            valid_q = data_valid;
        end
    end

    initial begin
        int strobes_before_idle;
        // reset for 8 clk cycles and released just after an edge
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        run_test_file();
        wait_queue_drained();
        // nothing more may come out in the quiet tail
        strobes_before_idle = strobe_count;
        repeat (FINAL_IDLE) @(posedge clk);
        assert (strobe_count == strobes_before_idle) else begin
            $display("%0d data_valid strobes during the final idle period",
                     strobe_count - strobes_before_idle);
            protocol_errors++;
        end
        assert (strobe_count == accepted_count) else begin
            $display("[ERROR] strobe count expected %h actual %h", accepted_count, strobe_count);
            data_errors++;
        end
        report_and_finish();
    end

endmodule

// ==== list.f ====
hw/link_pkg.sv
hw/rx_pkg.sv
hw/link_capture.sv
hw/flag_sync.sv
hw/word_selector.sv
hw/strobe_link_rx.sv
testbench/tb_strobe_link_rx.sv

// ==== Makefile ====
# Verilator build of the strobe link receiver testbench
# run from the project root so the test file path resolves

TOP := tb_strobe_link_rx
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/link_tests.txt ====
# one command per line: send <hex word> <a|d>, idle <link cycles>, active <0|1>,
# random <count> <a|d>, end; a = receiver must deliver the word, d = must drop it
idle 3
active 1
idle 2
# single words with gaps, three laps of the slot ring
send 12345678 a
idle 5
send 9abcdef0 a
idle 5
send 00000000 a
idle 5
send ffffffff a
idle 4
send 0badcafe a
idle 4
send deadbeef a
idle 3
send a5a5a5a5 a
idle 3
send 5a5a5a5a a
idle 3
send 00000001 a
idle 8
# link drops after nine words, these must vanish
active 0
send 11111111 d
idle 2
send 22222222 d
send 33333333 d
idle 6
# link back, ring restarts at slot 0
active 1
send 80000000 a
idle 2
send 7fffffff a
idle 2
send c0ffee00 a
idle 1
send 13579bdf a
idle 1
send 2468ace0 a
send fedcba98 a
idle 8
# burst at one word per link cycle
random 30 a
active 0
send 44444444 d
idle 4
end
